// ==== files.f ====
+incdir+source
source/imm_decode_pkg.sv
source/decode_if.sv
source/fp_cvt32_to_64.sv
source/decode_imm.sv
source/prefix_merge.sv
source/apb_decode_regs.sv
source/imm_decode_top.sv
verification/tb_imm_decode.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_imm_decode -f files.f \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_imm_decode > sim.log 2>&1
cat sim.log

grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

// ==== source/apb_decode_regs.sv ====
// APB slave with zero wait states, every transfer takes setup plus access
// Writing REG_INSN_HI launches a decode of {INSN_HI, INSN_LO}
`include "imm_decode_cfg.svh"

module apb_decode_regs (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`IMM_APB_ADDR_W-1:0] paddr,
	input logic [`IMM_APB_DATA_W-1:0] pwdata,
	output logic [`IMM_APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	decode_if.regs dif
);

	logic access, mapped, read_only, wr_ok;
	logic [31:0] insn_lo;
	logic [`IMM_VALUE_W-1:0] res_imma, res_immb, res_immc;
	logic [2:0] res_has;
	logic [31:0] count;

	assign access = psel & penable;

	// ========================================
	// Address decode and read mux
	// ========================================
	always_comb
	begin
		mapped = 1'b1;
		read_only = 1'b1;
		prdata = '0;
		case (paddr)
		`REG_INSN_LO:
			begin
				prdata = insn_lo;
				read_only = 1'b0;
			end
		`REG_INSN_HI:
			begin
				prdata = dif.insn[63:32];
				read_only = 1'b0;
			end
		// Has flags of the last result next to the live pending flags
		`REG_STATUS: prdata = {25'd0, dif.pending, 1'b0, res_has};
		`REG_IMMA_LO: prdata = res_imma[31:0];
		`REG_IMMA_HI: prdata = res_imma[`IMM_VALUE_W-1:32];
		`REG_IMMB_LO: prdata = res_immb[31:0];
		`REG_IMMB_HI: prdata = res_immb[`IMM_VALUE_W-1:32];
		`REG_IMMC_LO: prdata = res_immc[31:0];
		`REG_IMMC_HI: prdata = res_immc[`IMM_VALUE_W-1:32];
		`REG_COUNT: prdata = count;
		default: mapped = 1'b0;
		endcase
	end

	assign pready = 1'b1;
	assign pslverr = access & (~mapped | (pwrite & read_only));
	assign wr_ok = access & pwrite & ~pslverr;

	// Instruction words and the decode trigger
	always_ff @(posedge clk)
	begin
		if (reset)
			dif.insn_valid <= 1'b0;
		else
			dif.insn_valid <= wr_ok && paddr == `REG_INSN_HI;
		if (wr_ok && paddr == `REG_INSN_LO)
			insn_lo <= pwdata;
		if (wr_ok && paddr == `REG_INSN_HI)
			dif.insn <= {pwdata, insn_lo};
	end

	// ========================================
	// Result capture
	// ========================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			res_has <= 3'b000;
			count <= 32'd0;
		end
		else if (dif.merged_valid)
		begin
			res_has <= {dif.merged.has_immc, dif.merged.has_immb, dif.merged.has_imma};
			count <= count + 32'd1;
		end
		if (dif.merged_valid)
		begin
			res_imma <= dif.merged.imma;
			res_immb <= dif.merged.immb;
			res_immc <= dif.merged.immc;
		end
	end

	// The master must run a setup phase before every access phase
	assert property (@(posedge clk) disable iff (reset) penable |-> psel);

endmodule

// ==== source/decode_if.sv ====
// Link between the register block, the decoder and the merge stage
// insn_valid is a single-cycle strobe and there is no back-pressure
interface decode_if import imm_decode_pkg::*; ();

	// Latched instruction word, stable from one strobe to the next
	instruction_t insn;
	logic insn_valid;

	// Combinational decode of insn
	decode_result_t raw;

	// Registered results after prefix folding
	decode_result_t merged;
	logic merged_valid;
	// Pending prefix flags with c in bit 2 and a in bit 0
	logic [2:0] pending;

	modport regs (
		output insn, insn_valid,
		input merged, merged_valid, pending
	);

	modport decoder (
		input insn,
		output raw
	);

	modport merger (
		input insn_valid, raw,
		output merged, merged_valid, pending
	);

endinterface

// ==== source/decode_imm.sv ====
// Immediate operand decoder for the opcodes in imm_decode_pkg
// Unlisted opcodes decode to zero values with no immediate flags
`include "imm_decode_cfg.svh"

module decode_imm
	import imm_decode_pkg::*;
(
	decode_if.decoder dif
);

	decode_result_t res;
	logic [63:0] flt_dbl;

	// FLTI carries a single precision constant in the upper word
	fp_cvt32_to_64 u_cvt (
		.single(dif.insn.imm32.imm),
		.dbl(flt_dbl)
	);

	// ========================================
	// Opcode decode
	// ========================================
	always_comb
	begin
		res = '0;
		case (dif.insn.any.opcode)
		OP_R2:
			begin
				// Only the byte index function carries an immediate
				if (dif.insn.r3.func == FN_BYTENDX)
				begin
					res.immb = {{(`IMM_VALUE_W-10){dif.insn[38]}}, dif.insn[38:29]};
					res.has_immb = 1'b1;
				end
			end
		OP_ADDI:
			begin
				res.immb = {{(`IMM_VALUE_W-32){dif.insn[63]}}, dif.insn.imm32.imm};
				res.has_immb = 1'b1;
			end
		OP_ANDI:
			begin
				// Upper bits read as ones so the mask keeps them
				res.immb = {{(`IMM_VALUE_W-32){1'b1}}, dif.insn.imm32.imm};
				res.has_immb = 1'b1;
			end
		OP_ORI:
			begin
				res.immb = {{(`IMM_VALUE_W-32){1'b0}}, dif.insn.imm32.imm};
				res.has_immb = 1'b1;
			end
		OP_SHIFT:
			begin
				// The i flag tells a constant shift amount from a register one
				res.immc = {{(`IMM_VALUE_W-7){1'b0}}, dif.insn.shifti.amt};
				res.has_immc = dif.insn.shifti.i;
			end
		OP_LDO, OP_STO:
			begin
				res.immb = {{(`IMM_VALUE_W-21){dif.insn.ls.disp[20]}}, dif.insn.ls.disp};
				res.has_immb = 1'b1;
			end
		OP_BCC:
			begin
				// Branch displacement goes to operand c
				res.immc = {{(`IMM_VALUE_W-24){dif.insn.br.disp[23]}}, dif.insn.br.disp};
				res.has_immc = 1'b1;
			end
		OP_FLTI:
			begin
				res.immb = flt_dbl;
				res.has_immb = 1'b1;
			end
		OP_PFXAB:
			begin
				// The sw bit picks operand b, otherwise operand a
				if (dif.insn.pfx.sw)
				begin
					res.immb = {dif.insn.pfx.imm, 8'h00};
					res.has_immb = 1'b1;
					res.pfxb = 1'b1;
				end
				else
				begin
					res.imma = {dif.insn.pfx.imm, 8'h00};
					res.has_imma = 1'b1;
					res.pfxa = 1'b1;
				end
			end
		OP_PFXC:
			begin
				res.immc = {dif.insn.pfx.imm, 8'h00};
				res.has_immc = 1'b1;
				res.pfxc = 1'b1;
			end
		default:
			begin
				res = '0;
			end
		endcase
	end

	assign dif.raw = res;

endmodule

// ==== source/fp_cvt32_to_64.sv ====
// Single to double precision widening, purely combinational
// Denormal inputs are flushed to a zero of the same sign
module fp_cvt32_to_64 (
	input logic [31:0] single,
	output logic [63:0] dbl
);

	logic sgn;
	logic [7:0] exp_s;
	logic [22:0] frac_s;
	logic [10:0] exp_d;

	// Split the single precision fields
	assign sgn = single[31];
	assign exp_s = single[30:23];
	assign frac_s = single[22:0];

	// Move the exponent bias from 127 to 1023
	assign exp_d = {3'b000, exp_s} + 11'd896;

	always_comb
	begin
		if (exp_s == 8'h00)
		begin
			// Zero stays zero, and a denormal drops its fraction too
			dbl = {sgn, 63'd0};
		end
		else if (exp_s == 8'hFF)
		begin
			// Infinity and NaN keep the payload under the all-ones exponent
			dbl = {sgn, 11'h7FF, frac_s, 29'd0};
		end
		else
		begin
			// Normal number with the fraction left aligned in 52 bits
			dbl = {sgn, exp_d, frac_s, 29'd0};
		end
	end

endmodule

// ==== source/imm_decode_cfg.svh ====
// Widths and APB register map for the immediate decode peripheral
// The APB data bus is 32 bits, so each 64-bit value spans two registers
`ifndef IMM_DECODE_CFG_SVH
`define IMM_DECODE_CFG_SVH

// ========================================
// Datapath widths
// ========================================
`define IMM_VALUE_W 64
`define IMM_INSN_W 64

// APB bus widths as seen at the top level
`define IMM_APB_ADDR_W 8
`define IMM_APB_DATA_W 32

// ========================================
// APB byte offsets
// ========================================
`define REG_INSN_LO 8'h00
`define REG_INSN_HI 8'h04
`define REG_STATUS 8'h08
`define REG_IMMA_LO 8'h10
`define REG_IMMA_HI 8'h14
`define REG_IMMB_LO 8'h18
`define REG_IMMB_HI 8'h1C
`define REG_IMMC_LO 8'h20
`define REG_IMMC_HI 8'h24
`define REG_COUNT 8'h28

`endif

// ==== source/imm_decode_pkg.sv ====
// Opcode encodings and instruction formats for the immediate decoder only
// Every view of the instruction union is exactly one 64-bit word
`include "imm_decode_cfg.svh"

package imm_decode_pkg;

	// ========================================
	// Opcodes and function codes
	// ========================================

	// Major opcode lives in bits 6:0 of every format
	typedef enum logic [6:0] {
		OP_R2    = 7'h02,
		OP_ADDI  = 7'h04,
		OP_ANDI  = 7'h08,
		OP_ORI   = 7'h09,
		OP_FLTI  = 7'h0C,
		OP_BCC   = 7'h28,
		OP_LDO   = 7'h46,
		OP_STO   = 7'h50,
		OP_SHIFT = 7'h58,
		OP_PFXAB = 7'h7C,
		OP_PFXC  = 7'h7D
	} opcode_t;

	// Function code of the register format sits in the top six bits
	typedef enum logic [5:0] {
		FN_ADD     = 6'h04,
		FN_SUB     = 6'h05,
		FN_AND     = 6'h08,
		FN_OR      = 6'h09,
		FN_BYTENDX = 6'h36
	} func_t;

	// ========================================
	// Instruction formats
	// ========================================

	// Same word seen through each encoding the decoder understands
	typedef union packed {
		struct packed {logic [56:0] payload; opcode_t opcode;} any;
		struct packed {
			func_t func; logic [6:0] rs3; logic [6:0] rs2; logic [6:0] rs1;
			logic [22:0] ctrl; logic [6:0] rd; opcode_t opcode;
		} r3;
		struct packed {
			logic [31:0] imm; logic [6:0] rs1; logic [10:0] ctrl;
			logic [6:0] rd; opcode_t opcode;
		} imm32;
		struct packed {
			logic [20:0] disp; logic [6:0] base; logic [6:0] ndx;
			logic [14:0] ctrl; logic [6:0] rd; opcode_t opcode;
		} ls;
		struct packed {
			logic [23:0] disp; logic [6:0] ra; logic [6:0] rb;
			logic [3:0] cnd; logic [14:0] ctrl; opcode_t opcode;
		} br;
		struct packed {
			logic [32:0] rsvd; logic [6:0] rs1; logic i; logic [6:0] amt;
			logic [1:0] ctrl; logic [6:0] rd; opcode_t opcode;
		} shifti;
		struct packed {logic [55:0] imm; logic sw; opcode_t opcode;} pfx;
	} instruction_t;

	// ========================================
	// Decode results
	// ========================================

	// Immediates plus flags telling which operands carry one
	typedef struct packed {
		logic [`IMM_VALUE_W-1:0] imma;
		logic [`IMM_VALUE_W-1:0] immb;
		logic [`IMM_VALUE_W-1:0] immc;
		logic has_imma;
		logic has_immb;
		logic has_immc;
		logic pfxa;
		logic pfxb;
		logic pfxc;
	} decode_result_t;

endpackage

// ==== source/imm_decode_top.sv ====
// Immediate decode peripheral with an APB slave port
// Results read back three cycles after the access cycle of the INSN_HI write
`include "imm_decode_cfg.svh"

module imm_decode_top (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`IMM_APB_ADDR_W-1:0] paddr,
	input logic [`IMM_APB_DATA_W-1:0] pwdata,
	output logic [`IMM_APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	// Shared decode bundle between the three stages
	decode_if dif ();

	// Register block latches the instruction and holds results
	apb_decode_regs u_regs (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.dif(dif.regs)
	);

	// Combinational immediate decode of the latched word
	decode_imm u_decode (
		.dif(dif.decoder)
	);

	// Prefix folding and result register
	prefix_merge u_merge (
		.clk(clk),
		.reset(reset),
		.dif(dif.merger)
	);

endmodule

// ==== source/prefix_merge.sv ====
// Folds pending prefix values into the next non-prefix instruction
// Prefix words raise no merged_valid, and all prefixes drop after one use
`include "imm_decode_cfg.svh"

module prefix_merge
	import imm_decode_pkg::*;
(
	input logic clk,
	input logic reset,
	decode_if.merger dif
);

	logic is_pfx;
	// Upper 56 bits of each pending prefix value
	logic [`IMM_VALUE_W-1:8] pfx_a, pfx_b, pfx_c;
	decode_result_t merged_next;

	assign is_pfx = dif.raw.pfxa | dif.raw.pfxb | dif.raw.pfxc;

	// ========================================
	// Merge of pending prefixes
	// ========================================
	always_comb
	begin
		merged_next = dif.raw;
		// The prefix supplies the upper bits and the instruction the low byte
		if (dif.pending[0] && dif.raw.has_imma)
			merged_next.imma = {pfx_a, dif.raw.imma[7:0]};
		if (dif.pending[1] && dif.raw.has_immb)
			merged_next.immb = {pfx_b, dif.raw.immb[7:0]};
		if (dif.pending[2] && dif.raw.has_immc)
			merged_next.immc = {pfx_c, dif.raw.immc[7:0]};
	end

	// Pending flags and the result strobe
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dif.pending <= 3'b000;
			dif.merged_valid <= 1'b0;
		end
		else
		begin
			dif.merged_valid <= dif.insn_valid & ~is_pfx;
			if (dif.insn_valid)
			begin
				if (is_pfx)
					dif.pending <= dif.pending | {dif.raw.pfxc, dif.raw.pfxb, dif.raw.pfxa};
				else
					dif.pending <= 3'b000;
			end
		end
	end

	// Prefix values and merged results
	always_ff @(posedge clk)
	begin
		if (dif.insn_valid && dif.raw.pfxa)
			pfx_a <= dif.raw.imma[`IMM_VALUE_W-1:8];
		if (dif.insn_valid && dif.raw.pfxb)
			pfx_b <= dif.raw.immb[`IMM_VALUE_W-1:8];
		if (dif.insn_valid && dif.raw.pfxc)
			pfx_c <= dif.raw.immc[`IMM_VALUE_W-1:8];
		if (dif.insn_valid && !is_pfx)
			dif.merged <= merged_next;
	end

	// A result appears exactly one cycle after a non-prefix strobe
	assert property (@(posedge clk) disable iff (reset)
		dif.merged_valid |-> $past(dif.insn_valid));

endmodule

// ==== verification/tb_imm_decode.sv ====
// Table-driven testbench for the APB immediate decode peripheral
// Random fields use a fixed seed and float cases carry precomputed doubles
// Results are read three cycles after the INSN_HI write, as the pipeline fixes
`include "imm_decode_cfg.svh"

module tb_imm_decode
	import imm_decode_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 20;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	// Stimulus table with one instruction per entry
	logic [63:0] tab_insn[$];
	logic [63:0] tab_immb[$];
	logic [63:0] tab_immc[$];
	logic [7:0] tab_status[$];
	logic tab_err[$];

	// Last expected result, which a prefix word leaves in place
	logic [63:0] last_immb;
	logic [63:0] last_immc;
	logic [2:0] last_has;

	imm_decode_top uut (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #50 clk = ~clk;

	// ========================================
	// Checking and APB tasks
	// ========================================
	task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task report_timeout(input string what);
		$display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	endtask

	// Setup cycle, then access cycle until pready, then back to idle
	task apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int waited;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		waited = 0;
		@(posedge clk);
		while (pready !== 1'b1)
		begin
			if (waited == TIMEOUT_CYCLES)
				report_timeout("pready");
			waited++;
			@(posedge clk);
		end
		// Sampled at the edge that ends the access cycle
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apb_transfer(1'b0, addr, 32'd0, data, err);
	endtask

	// A 64-bit result sits in a LO register with its HI word four bytes up
	task read_wide(input logic [7:0] lo_addr, output logic [63:0] value);
		logic [31:0] lo;
		logic [31:0] hi;
		logic err;
		apb_read(lo_addr, lo, err);
		check_value("pslverr", err, 0);
		apb_read(lo_addr + 8'h04, hi, err);
		check_value("pslverr", err, 0);
		value = {hi, lo};
	endtask

	// ========================================
	// Table construction
	// ========================================
	task add_result(input logic [63:0] insn, input logic [63:0] immb, input logic [63:0] immc,
		input logic [2:0] has);
		tab_insn.push_back(insn);
		tab_immb.push_back(immb);
		tab_immc.push_back(immc);
		// Pending flags are always clear after a non-prefix word
		tab_status.push_back({5'd0, has});
		tab_err.push_back(1'b0);
		last_immb = immb;
		last_immc = immc;
		last_has = has;
	endtask

	// A prefix leaves the results alone and only raises its pending flag
	task add_prefix(input logic [63:0] insn, input logic [2:0] pend);
		tab_insn.push_back(insn);
		tab_immb.push_back(last_immb);
		tab_immc.push_back(last_immc);
		tab_status.push_back({1'b0, pend, 1'b0, last_has});
		tab_err.push_back(1'b0);
	endtask

	task add_float(input logic [31:0] single, input logic [63:0] dbl);
		logic [31:0] low;
		low = $urandom;
		add_result({single, low[31:7], OP_FLTI}, dbl, 64'd0, 3'b010);
	endtask

	task build_table();
		logic [63:0] r;
		logic [31:0] w;
		logic [55:0] pimm;
		// Sign extension with a negative and then a positive field
		w = $urandom | 32'h8000_0000;
		r = {$urandom, $urandom};
		add_result({w, r[31:7], OP_ADDI}, {{32{w[31]}}, w}, 64'd0, 3'b010);
		w = $urandom & 32'h7FFF_FFFF;
		add_result({w, r[31:7], OP_ADDI}, {{32{w[31]}}, w}, 64'd0, 3'b010);
		w = $urandom;
		add_result({w, r[31:7], OP_ANDI}, {32'hFFFF_FFFF, w}, 64'd0, 3'b010);
		w = $urandom;
		add_result({w, r[31:7], OP_ORI}, {32'h0, w}, 64'd0, 3'b010);
		// Load and store displacements of both signs
		r = {$urandom, $urandom};
		r[63] = 1'b1;
		add_result({r[63:7], OP_LDO}, {{43{r[63]}}, r[63:43]}, 64'd0, 3'b010);
		r = {$urandom, $urandom};
		r[63] = 1'b0;
		add_result({r[63:7], OP_STO}, {{43{r[63]}}, r[63:43]}, 64'd0, 3'b010);
		r = {$urandom, $urandom};
		add_result({r[63:7], OP_BCC}, 64'd0, {{40{r[63]}}, r[63:40]}, 3'b100);
		r = {$urandom, $urandom};
		r[38] = 1'b1;
		add_result({FN_BYTENDX, r[57:7], OP_R2}, {{54{r[38]}}, r[38:29]}, 64'd0, 3'b010);
		// Shift amount is decoded either way, but flagged only with i set
		r = {$urandom, $urandom};
		r[23] = 1'b1;
		add_result({r[63:7], OP_SHIFT}, 64'd0, {57'd0, r[22:16]}, 3'b100);
		r[23] = 1'b0;
		add_result({r[63:7], OP_SHIFT}, 64'd0, {57'd0, r[22:16]}, 3'b000);
		r = {$urandom, $urandom};
		add_result({r[63:7], 7'h7F}, 64'd0, 64'd0, 3'b000);
		// Float widening, including the special encodings
		add_float(32'h3F80_0000, 64'h3FF0_0000_0000_0000);
		add_float(32'hC020_0000, 64'hC004_0000_0000_0000);
		add_float(32'h8000_0000, 64'h8000_0000_0000_0000);
		add_float(32'h7F80_0000, 64'h7FF0_0000_0000_0000);
		add_float(32'h7FC0_0001, 64'h7FF8_0000_2000_0000);
		add_float(32'h0000_0001, 64'h0000_0000_0000_0000);
		add_float(32'h807F_FFFF, 64'h8000_0000_0000_0000);
		// Prefix on operand b folds into the ADDI immediate
		r = {$urandom, $urandom};
		pimm = r[55:0];
		add_prefix({pimm, 1'b1, OP_PFXAB}, 3'b010);
		w = $urandom;
		add_result({w, r[31:7], OP_ADDI}, {pimm, w[7:0]}, 64'd0, 3'b010);
		// Prefix on operand c folds into the branch displacement
		r = {$urandom, $urandom};
		pimm = r[55:0];
		add_prefix({pimm, r[7], OP_PFXC}, 3'b100);
		r = {$urandom, $urandom};
		add_result({r[63:7], OP_BCC}, 64'd0, {pimm, r[47:40]}, 3'b100);
		// An unused prefix on operand a still clears after ORI
		r = {$urandom, $urandom};
		add_prefix({r[55:0], 1'b0, OP_PFXAB}, 3'b001);
		w = $urandom;
		add_result({w, r[31:7], OP_ORI}, {32'h0, w}, 64'd0, 3'b010);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial
	begin
		int exp_count;
		logic err;
		logic [31:0] data;
		logic [63:0] value;
		void'($urandom(37576));
		clk = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'd0;
		pwdata = 32'd0;
		last_immb = 64'd0;
		last_immc = 64'd0;
		last_has = 3'b000;
		build_table();
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Counter and status start from zero
		apb_read(`REG_COUNT, data, err);
		check_value("count", data, 0);
		apb_read(`REG_STATUS, data, err);
		check_value("status", data, 0);

		exp_count = 0;
		for (int i = 0; i < tab_insn.size(); i++)
		begin
			apb_write(`REG_INSN_LO, tab_insn[i][31:0], err);
			check_value("pslverr", err, tab_err[i]);
			apb_write(`REG_INSN_HI, tab_insn[i][63:32], err);
			check_value("pslverr", err, tab_err[i]);
			if (tab_insn[i][6:0] != OP_PFXAB && tab_insn[i][6:0] != OP_PFXC)
				exp_count++;
			repeat (3) @(posedge clk);
			read_wide(`REG_INSN_LO, value);
			check_value("insn", value, tab_insn[i]);
			// No listed non-prefix opcode carries an operand a immediate
			read_wide(`REG_IMMA_LO, value);
			check_value("imma", value, 64'd0);
			read_wide(`REG_IMMB_LO, value);
			check_value("immb", value, tab_immb[i]);
			read_wide(`REG_IMMC_LO, value);
			check_value("immc", value, tab_immc[i]);
			apb_read(`REG_STATUS, data, err);
			check_value("status", data, {24'd0, tab_status[i]});
			apb_read(`REG_COUNT, data, err);
			check_value("count", data, exp_count);
		end

		// Unmapped offsets and read-only registers answer with pslverr
		apb_read(8'h0C, data, err);
		check_value("pslverr", err, 1);
		apb_read(8'h40, data, err);
		check_value("pslverr", err, 1);
		apb_write(`REG_STATUS, 32'hFFFF_FFFF, err);
		check_value("pslverr", err, 1);
		apb_write(`REG_COUNT, 32'd0, err);
		check_value("pslverr", err, 1);
		apb_read(`REG_COUNT, data, err);
		check_value("count", data, exp_count);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
